// ==== hw/ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

    // data and pc width
    localparam int xlen = 32;

    // parallel execution slots
    localparam int n_stations = 4;
    localparam int sta_w = 2;

    // reorder buffer size
    // tag_w has to cover rob_depth exactly, so tags wrap for free
    localparam int rob_depth = 8;
    localparam int tag_w = 3;

    // iterative multiplier
    // 4 cycles, one byte of the multiplier per cycle
    localparam int mul_steps = 4;
    localparam int mul_bits = xlen / mul_steps;
    localparam int mul_cnt_w = $clog2(mul_steps);

    // decoded operation codes
    // op_jal writes pc + 4 and jumps to a + b
    // op_halt writes nothing, end of program marker
    typedef enum logic [2:0] {
        op_add  = 3'd0,
        op_sub  = 3'd1,
        op_xor  = 3'd2,
        op_slt  = 3'd3,
        op_mul  = 3'd4,
        op_jal  = 3'd5,
        op_halt = 3'd6
    } op_t;

endpackage

`default_nettype wire

// ==== hw/dispatch.sv ====
`default_nettype none

module dispatch import ooo_pkg::*; (
    input  logic                  itf,
    input  logic                  rst,
    // issue port, valid/ready
    input  logic                  issue_valid,
    input  op_t                   issue_op,
    input  logic [xlen-1:0]       issue_a,
    input  logic [xlen-1:0]       issue_b,
    input  logic [xlen-1:0]       issue_pc,
    input  logic [4:0]            issue_rd,
    output logic                  issue_ready,
    // station status and rob status
    input  logic [n_stations-1:0] busy,
    input  logic                  full,
    // shared station operand bus
    output logic [n_stations-1:0] start,
    output op_t                   st_op,
    output logic [xlen-1:0]       st_a,
    output logic [xlen-1:0]       st_b,
    output logic [xlen-1:0]       st_pc,
    output logic [tag_w-1:0]      st_tag,
    // rob allocation
    output logic                  alloc,
    output logic [tag_w-1:0]      alloc_tag,
    output logic [xlen-1:0]       alloc_pc,
    output logic [4:0]            alloc_rd,
    output op_t                   alloc_op
);

    logic [n_stations-1:0] free;
    logic [sta_w-1:0]      pick;
    logic                  any_free;
    logic                  accept;
    logic [tag_w-1:0]      tail;

    // station with a start in flight does not show busy yet
    assign free = ~busy & ~start;

    // lowest free index wins
    always_comb begin
        pick = '0;
        any_free = 1'b0;
        for (int i = n_stations - 1; i >= 0; i--) begin
            if (free[i]) begin
                pick = sta_w'(i);
                any_free = 1'b1;
            end
        end
    end

    // full already accounts for the alloc being sent this cycle
    assign issue_ready = !full && any_free;
    assign accept = issue_valid && issue_ready;

    // strobes and tag counter
    always_ff @(posedge itf) begin
        if (rst) begin
            start <= '0;
            alloc <= 1'b0;
            tail <= '0;
        end else begin
            start <= accept ? (n_stations'(1) << pick) : '0;
            alloc <= accept;
            // tag_w bits wrap at rob_depth
            if (accept) begin
                tail <= tail + 1'b1;
            end
        end
    end

    // operand bus, valid only with a start bit
    always_ff @(posedge itf) begin
        if (accept) begin
            st_op <= issue_op;
            st_a <= issue_a;
            st_b <= issue_b;
            st_pc <= issue_pc;
            st_tag <= tail;
            alloc_rd <= issue_rd;
        end
    end

    // rob entry shares pc, op and tag with the station bus
    assign alloc_tag = st_tag;
    assign alloc_pc = st_pc;
    assign alloc_op = st_op;

    // at most one station kicked per cycle, and never one that is still working
    assert property (@(posedge itf) disable iff (rst)
        $onehot0(start) && !(|(start & busy)))
        else $error("dispatch: start not one-hot or sent to a busy station");

endmodule

`default_nettype wire

// ==== hw/res_station.sv ====
`default_nettype none

module res_station import ooo_pkg::*; (
    input  logic             itf,
    input  logic             rst,
    input  logic             start,
    input  op_t              op,
    input  logic [xlen-1:0]  a,
    input  logic [xlen-1:0]  b,
    input  logic [xlen-1:0]  pc,
    input  logic [tag_w-1:0] tag,
    output logic             busy,
    output logic             done,
    output logic [tag_w-1:0] done_tag,
    output logic [xlen-1:0]  done_data,
    output logic [xlen-1:0]  done_target
);

    logic                 active;
    logic [mul_cnt_w-1:0] step;
    logic                 last;
    logic [xlen-1:0]      acc;
    logic [xlen-1:0]      mcand;
    logic [xlen-1:0]      mplier;
    logic [xlen-1:0]      part;
    logic [xlen-1:0]      alu_res;

    // shift and add over one slice of the multiplier
    function automatic logic [xlen-1:0] mul_slice(input logic [xlen-1:0] m,
                                                  input logic [mul_bits-1:0] bits);
        logic [xlen-1:0] sum;
        sum = '0;
        for (int j = 0; j < mul_bits; j++) begin
            if (bits[j]) begin
                sum = sum + (m << j);
            end
        end
        return sum;
    endfunction

    // single cycle ops
    always_comb begin
        unique case (op)
            op_add:  alu_res = a + b;
            op_sub:  alu_res = a - b;
            op_xor:  alu_res = a ^ b;
            op_slt:  alu_res = ($signed(a) < $signed(b)) ? xlen'(1) : '0;
            // link value
            op_jal:  alu_res = pc + xlen'(4);
            // halt retires with zero data
            default: alu_res = '0;
        endcase
    end

    // next partial product while the multiplier runs
    assign part = mul_slice(mcand, mplier[mul_bits-1:0]);
    assign last = step == mul_cnt_w'(mul_steps - 1);

    // only the multiplier holds the station
    assign busy = active;

    always_ff @(posedge itf) begin
        if (rst) begin
            active <= 1'b0;
            step <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                if (op == op_mul) begin
                    // first slice is taken on the start edge
                    active <= 1'b1;
                    step <= mul_cnt_w'(1);
                end else begin
                    done <= 1'b1;
                end
            end else if (active) begin
                step <= step + 1'b1;
                if (last) begin
                    active <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // datapath
    always_ff @(posedge itf) begin
        if (start) begin
            done_tag <= tag;
            // jump target, ignored by the rob unless op_jal
            done_target <= a + b;
            if (op == op_mul) begin
                acc <= mul_slice(a, b[mul_bits-1:0]);
                mcand <= a << mul_bits;
                mplier <= b >> mul_bits;
            end else begin
                done_data <= alu_res;
            end
        end else if (active) begin
            acc <= acc + part;
            mcand <= mcand << mul_bits;
            mplier <= mplier >> mul_bits;
            // low xlen bits of the product
            if (last) begin
                done_data <= acc + part;
            end
        end
    end

    // dispatch masks busy stations, so a new start never overlaps a multiply
    assert property (@(posedge itf) disable iff (rst) start |-> !active)
        else $error("res_station: start while busy");

endmodule

`default_nettype wire

// ==== hw/reorder_buffer.sv ====
`default_nettype none

module reorder_buffer import ooo_pkg::*; (
    input  logic                  itf,
    input  logic                  rst,
    // allocation from dispatch
    input  logic                  alloc,
    input  logic [tag_w-1:0]      alloc_tag,
    input  logic [xlen-1:0]       alloc_pc,
    input  logic [4:0]            alloc_rd,
    input  op_t                   alloc_op,
    // one completion port per station
    input  logic [n_stations-1:0] done,
    input  logic [tag_w-1:0]      done_tag [n_stations],
    input  logic [xlen-1:0]       done_data [n_stations],
    input  logic [xlen-1:0]       done_target [n_stations],
    output logic                  full,
    // in order retirement
    output logic                  commit,
    output logic [xlen-1:0]       commit_pc,
    output logic [4:0]            commit_rd,
    output op_t                   commit_op,
    output logic [xlen-1:0]       commit_data,
    output logic [xlen-1:0]       commit_target
);

    logic [rob_depth-1:0] valid;
    logic [rob_depth-1:0] rdy;
    logic [xlen-1:0]      pc_q [rob_depth];
    logic [4:0]           rd_q [rob_depth];
    op_t                  op_q [rob_depth];
    logic [xlen-1:0]      data_q [rob_depth];
    logic [xlen-1:0]      target_q [rob_depth];
    logic [tag_w-1:0]     head;
    logic [tag_w:0]       count;

    // an alloc in flight already holds a slot
    // commit in the same cycle is ignored, slightly pessimistic
    assign full = (count == (tag_w + 1)'(rob_depth))
                  || (alloc && count == (tag_w + 1)'(rob_depth - 1));

    // head retires once its result is in
    assign commit = valid[head] && rdy[head];
    assign commit_pc = pc_q[head];
    assign commit_rd = rd_q[head];
    assign commit_op = op_q[head];
    assign commit_data = data_q[head];
    assign commit_target = target_q[head];

    // entry state, head and occupancy
    always_ff @(posedge itf) begin
        if (rst) begin
            valid <= '0;
            rdy <= '0;
            head <= '0;
            count <= '0;
        end else begin
            if (commit) begin
                valid[head] <= 1'b0;
                rdy[head] <= 1'b0;
                head <= head + 1'b1;
            end
            // alloc slot is never the head of a non-empty buffer
            if (alloc) begin
                valid[alloc_tag] <= 1'b1;
                rdy[alloc_tag] <= 1'b0;
            end
            // all stations can land in the same cycle
            for (int i = 0; i < n_stations; i++) begin
                if (done[i]) begin
                    rdy[done_tag[i]] <= 1'b1;
                end
            end
            count <= count + (tag_w + 1)'(alloc) - (tag_w + 1)'(commit);
        end
    end

    // entry payload
    always_ff @(posedge itf) begin
        if (alloc) begin
            pc_q[alloc_tag] <= alloc_pc;
            rd_q[alloc_tag] <= alloc_rd;
            op_q[alloc_tag] <= alloc_op;
        end
        for (int i = 0; i < n_stations; i++) begin
            if (done[i]) begin
                data_q[done_tag[i]] <= done_data[i];
                target_q[done_tag[i]] <= done_target[i];
            end
        end
    end

    // completions only hit live, still pending entries
    for (genvar g = 0; g < n_stations; g++) begin : g_done_chk
        assert property (@(posedge itf) disable iff (rst)
            done[g] |-> valid[done_tag[g]] && !rdy[done_tag[g]])
            else $error("reorder_buffer: completion on tag %0d not pending", done_tag[g]);
    end

    // dispatch tail must land on a free slot of a buffer with room
    assert property (@(posedge itf) disable iff (rst)
        alloc |-> count != (tag_w + 1)'(rob_depth) && !valid[alloc_tag])
        else $error("reorder_buffer: alloc with no free entry");

endmodule

`default_nettype wire

// ==== hw/retire_monitor.sv ====
`default_nettype none

module retire_monitor import ooo_pkg::*; (
    input  logic            itf,
    input  logic            rst,
    // head entry from the rob
    input  logic            commit,
    input  logic [xlen-1:0] commit_pc,
    input  logic [4:0]      commit_rd,
    input  op_t             commit_op,
    input  logic [xlen-1:0] commit_data,
    input  logic [xlen-1:0] commit_target,
    // trace record
    output logic            retire_valid,
    output logic [xlen-1:0] retire_order,
    output logic [xlen-1:0] retire_pc,
    output logic [xlen-1:0] retire_next_pc,
    output logic [4:0]      retire_rd,
    output logic [xlen-1:0] retire_rd_data,
    output logic            retire_halt
);

    logic [xlen-1:0] next_order;

    // record strobe, order counter, halt flag
    always_ff @(posedge itf) begin
        if (rst) begin
            retire_valid <= 1'b0;
            retire_order <= '0;
            next_order <= '0;
            retire_halt <= 1'b0;
        end else begin
            retire_valid <= commit;
            retire_halt <= commit && commit_op == op_halt;
            // first record carries order 0
            if (commit) begin
                retire_order <= next_order;
                next_order <= next_order + 1'b1;
            end
        end
    end

    // record payload
    always_ff @(posedge itf) begin
        if (commit) begin
            retire_pc <= commit_pc;
            retire_rd <= commit_rd;
            // only a jump leaves the sequential path
            retire_next_pc <= (commit_op == op_jal) ? commit_target : commit_pc + xlen'(4);
            // x0 always reads as zero
            retire_rd_data <= (commit_rd == 5'd0) ? '0 : commit_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/ooo_core.sv ====
`default_nettype none

module ooo_core import ooo_pkg::*; (
    input  logic            itf,
    input  logic            rst,
    // issue
    input  logic            issue_valid,
    input  op_t             issue_op,
    input  logic [xlen-1:0] issue_a,
    input  logic [xlen-1:0] issue_b,
    input  logic [xlen-1:0] issue_pc,
    input  logic [4:0]      issue_rd,
    output logic            issue_ready,
    // retirement trace
    output logic            retire_valid,
    output logic [xlen-1:0] retire_order,
    output logic [xlen-1:0] retire_pc,
    output logic [xlen-1:0] retire_next_pc,
    output logic [4:0]      retire_rd,
    output logic [xlen-1:0] retire_rd_data,
    output logic            retire_halt
);

    // dispatch to stations
    logic [n_stations-1:0] start;
    logic [n_stations-1:0] busy;
    op_t                   st_op;
    logic [xlen-1:0]       st_a;
    logic [xlen-1:0]       st_b;
    logic [xlen-1:0]       st_pc;
    logic [tag_w-1:0]      st_tag;
    // dispatch to rob
    logic                  alloc;
    logic [tag_w-1:0]      alloc_tag;
    logic [xlen-1:0]       alloc_pc;
    logic [4:0]            alloc_rd;
    op_t                   alloc_op;
    logic                  full;
    // stations to rob
    logic [n_stations-1:0] done;
    logic [tag_w-1:0]      done_tag [n_stations];
    logic [xlen-1:0]       done_data [n_stations];
    logic [xlen-1:0]       done_target [n_stations];
    // rob to monitor
    logic                  commit;
    logic [xlen-1:0]       commit_pc;
    logic [4:0]            commit_rd;
    op_t                   commit_op;
    logic [xlen-1:0]       commit_data;
    logic [xlen-1:0]       commit_target;

    dispatch i_dispatch (
        .itf(itf), .rst(rst),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_a(issue_a),
        .issue_b(issue_b), .issue_pc(issue_pc), .issue_rd(issue_rd),
        .issue_ready(issue_ready), .busy(busy), .full(full), .start(start),
        .st_op(st_op), .st_a(st_a), .st_b(st_b), .st_pc(st_pc), .st_tag(st_tag),
        .alloc(alloc), .alloc_tag(alloc_tag), .alloc_pc(alloc_pc),
        .alloc_rd(alloc_rd), .alloc_op(alloc_op)
    );

    // all stations listen on the shared operand bus, start picks one
    for (genvar g = 0; g < n_stations; g++) begin : g_sta
        res_station i_res_station (
            .itf(itf), .rst(rst), .start(start[g]),
            .op(st_op), .a(st_a), .b(st_b), .pc(st_pc), .tag(st_tag),
            .busy(busy[g]), .done(done[g]), .done_tag(done_tag[g]),
            .done_data(done_data[g]), .done_target(done_target[g])
        );
    end

    reorder_buffer i_reorder_buffer (
        .itf(itf), .rst(rst),
        .alloc(alloc), .alloc_tag(alloc_tag), .alloc_pc(alloc_pc),
        .alloc_rd(alloc_rd), .alloc_op(alloc_op),
        .done(done), .done_tag(done_tag), .done_data(done_data),
        .done_target(done_target), .full(full),
        .commit(commit), .commit_pc(commit_pc), .commit_rd(commit_rd),
        .commit_op(commit_op), .commit_data(commit_data), .commit_target(commit_target)
    );

    retire_monitor i_retire_monitor (
        .itf(itf), .rst(rst),
        .commit(commit), .commit_pc(commit_pc), .commit_rd(commit_rd),
        .commit_op(commit_op), .commit_data(commit_data), .commit_target(commit_target),
        .retire_valid(retire_valid), .retire_order(retire_order),
        .retire_pc(retire_pc), .retire_next_pc(retire_next_pc),
        .retire_rd(retire_rd), .retire_rd_data(retire_rd_data),
        .retire_halt(retire_halt)
    );

endmodule

`default_nettype wire

// ==== verif/ooo_core_tb.sv ====
`default_nettype none

module ooo_core_tb import ooo_pkg::*; ();

    // golden record layout, one word per field
    localparam int rec_w = 8;
    localparam int f_op = 0;
    localparam int f_a = 1;
    localparam int f_b = 2;
    localparam int f_pc = 3;
    localparam int f_rd = 4;
    localparam int f_next_pc = 5;
    localparam int f_rd_data = 6;
    localparam int f_halt = 7;
    localparam int max_ops = 64;
    localparam int ready_limit = 200;
    localparam int retire_limit = 200;

    logic            itf;
    logic            rst;
    logic            issue_valid;
    op_t             issue_op;
    logic [xlen-1:0] issue_a;
    logic [xlen-1:0] issue_b;
    logic [xlen-1:0] issue_pc;
    logic [4:0]      issue_rd;
    logic            issue_ready;
    logic            retire_valid;
    logic [xlen-1:0] retire_order;
    logic [xlen-1:0] retire_pc;
    logic [xlen-1:0] retire_next_pc;
    logic [4:0]      retire_rd;
    logic [xlen-1:0] retire_rd_data;
    logic            retire_halt;

    logic [31:0] golden [max_ops * rec_w];
    int          pending [$];
    int          n_ops;
    int          received;
    int          stall_cycles;
    int          mismatches;
    int          protocol_errors;
    int          timeouts;
    bit          aborted;
    logic [15:0] lfsr;

    ooo_core i_dut (
        .itf(itf), .rst(rst),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_a(issue_a),
        .issue_b(issue_b), .issue_pc(issue_pc), .issue_rd(issue_rd),
        .issue_ready(issue_ready),
        .retire_valid(retire_valid), .retire_order(retire_order),
        .retire_pc(retire_pc), .retire_next_pc(retire_next_pc),
        .retire_rd(retire_rd), .retire_rd_data(retire_rd_data),
        .retire_halt(retire_halt)
    );

    always begin
        #5 itf = ~itf;
    end

    // 16 bit galois lfsr, maximal length taps
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hb400;
        end
        return s >> 1;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            mismatches++;
        end
    endtask

    // called on a falling edge, returns on the falling edge after the accept
    task automatic issue_one(input int k, output bit ok);
        int waited;
        waited = 0;
        ok = 1'b1;
        issue_valid = 1'b1;
        issue_op = op_t'(golden[k * rec_w + f_op][2:0]);
        issue_a = golden[k * rec_w + f_a];
        issue_b = golden[k * rec_w + f_b];
        issue_pc = golden[k * rec_w + f_pc];
        issue_rd = golden[k * rec_w + f_rd][4:0];
        // ready only depends on registered state, stable at the falling edge
        while (!issue_ready && ok) begin
            stall_cycles++;
            waited++;
            if (waited > ready_limit) begin
                $display("timeout: issue_ready stayed low for %0d cycles at op %0d",
                         waited, k);
                timeouts++;
                ok = 1'b0;
            end else begin
                @(negedge itf);
            end
        end
        if (ok) begin
            pending.push_back(k);
            @(negedge itf);
        end
        issue_valid = 1'b0;
    endtask

    task automatic drive_all();
        bit         ok;
        logic [1:0] gap;
        for (int k = 0; k < n_ops && !aborted; k++) begin
            // muls go back to back to fill the stations
            if (op_t'(golden[k * rec_w + f_op][2:0]) != op_mul) begin
                lfsr = lfsr_next(lfsr);
                gap[0] = lfsr[0];
                lfsr = lfsr_next(lfsr);
                gap[1] = lfsr[0];
                repeat (gap) @(negedge itf);
            end
            issue_one(k, ok);
            if (!ok) begin
                aborted = 1'b1;
            end
        end
    endtask

    // oldest pending op must be the one retiring
    task automatic check_record();
        int k;
        if (pending.size() == 0) begin
            $display("error: retirement with order %0d while nothing was pending",
                     retire_order);
            protocol_errors++;
        end else begin
            k = pending.pop_front();
            check_value($sformatf("op %0d order", k), 32'(received), retire_order);
            check_value($sformatf("op %0d pc", k), golden[k * rec_w + f_pc], retire_pc);
            check_value($sformatf("op %0d next_pc", k), golden[k * rec_w + f_next_pc],
                        retire_next_pc);
            check_value($sformatf("op %0d rd", k), golden[k * rec_w + f_rd],
                        32'(retire_rd));
            check_value($sformatf("op %0d rd_data", k), golden[k * rec_w + f_rd_data],
                        retire_rd_data);
            check_value($sformatf("op %0d halt", k), golden[k * rec_w + f_halt],
                        32'(retire_halt));
        end
        received++;
    endtask

    task automatic collect_all();
        int idle;
        idle = 0;
        while (received < n_ops && !aborted) begin
            @(negedge itf);
            if (retire_valid) begin
                idle = 0;
                check_record();
            end else begin
                idle++;
                if (idle > retire_limit) begin
                    $display("timeout: no retirement for %0d cycles, %0d of %0d seen",
                             idle, received, n_ops);
                    timeouts++;
                    aborted = 1'b1;
                end
            end
        end
    endtask

    // nothing may retire after halt, extras still count as retirements
    task automatic watch_quiet();
        repeat (20) begin
            @(negedge itf);
            if (retire_valid) begin
                $display("extra retirement with order %0d after the last op",
                         retire_order);
                received++;
            end
        end
    endtask

    initial begin
        itf = 1'b0;
        rst = 1'b1;
        issue_valid = 1'b0;
        issue_op = op_add;
        issue_a = '0;
        issue_b = '0;
        issue_pc = '0;
        issue_rd = '0;
        received = 0;
        stall_cycles = 0;
        mismatches = 0;
        protocol_errors = 0;
        timeouts = 0;
        aborted = 1'b0;
        lfsr = 16'd6;
        // op words above 7 mark the end of the records
        for (int i = 0; i < max_ops * rec_w; i++) begin
            golden[i] = 32'hbad0_0000 ^ 32'(i);
        end
        $readmemh("verif/golden_ops.txt", golden);
        n_ops = 0;
        while (n_ops < max_ops && golden[n_ops * rec_w + f_op] < 32'd8) begin
            n_ops++;
        end
        repeat (8) @(posedge itf);
        @(negedge itf);
        rst = 1'b0;
        check_value("reset issue_ready", 32'd1, 32'(issue_ready));
        check_value("reset retire_valid", 32'd0, 32'(retire_valid));
        check_value("reset retire_order", 32'd0, retire_order);
        if (n_ops == 0) begin
            $display("error: no records found in the golden file");
            protocol_errors++;
        end else begin
            check_value("last golden op is halt", 32'(op_halt),
                        golden[(n_ops - 1) * rec_w + f_op]);
            fork
                drive_all();
                collect_all();
            join
            if (!aborted) begin
                watch_quiet();
                check_value("retirement count", 32'(n_ops), 32'(received));
                check_value("issue_ready dropped in mul burst", 32'd1,
                            32'(stall_cycles > 0));
            end
        end
        $display("errors: %0d mismatches, %0d protocol errors, %0d timeouts",
                 mismatches, protocol_errors, timeouts);
        if (mismatches + protocol_errors + timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
hw/ooo_pkg.sv
hw/dispatch.sv
hw/res_station.sv
hw/reorder_buffer.sv
hw/retire_monitor.sv
hw/ooo_core.sv
verif/ooo_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the ooo_core testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f list.f --top-module ooo_core_tb -o ooo_core_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/ooo_core_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" "$log"; then
    exit 1
fi

if ! grep -q "test passed" "$log"; then
    echo "no result line found in $log"
    exit 1
fi

exit 0

// ==== verif/golden_ops.txt ====
// op a b pc rd, then expected next_pc rd_data halt, all hex
// ops: 0 add, 1 sub, 2 xor, 3 slt, 4 mul, 5 jal, 6 halt
0 00000005 00000007 00000100 01 00000104 0000000c 0
1 00000003 00000008 00000104 02 00000108 fffffffb 0
2 f0f0f0f0 0ff00ff0 00000108 03 0000010c ff00ff00 0
3 fffffffe 00000001 0000010c 04 00000110 00000001 0
3 00000001 fffffffe 00000110 05 00000114 00000000 0
3 fffffff0 fffffffe 00000114 06 00000118 00000001 0
4 00000007 00000006 00000118 07 0000011c 0000002a 0
0 00000001 00000001 0000011c 08 00000120 00000002 0
0 00000010 00000020 00000120 09 00000124 00000030 0
4 00012345 00010000 00000124 0a 00000128 23450000 0
4 ffffffff ffffffff 00000128 0b 0000012c 00000001 0
5 00000200 00000010 0000012c 01 00000210 00000130 0
0 00000004 00000005 00000210 00 00000214 00000000 0
5 00000300 00000000 00000214 00 00000300 00000000 0
2 12345678 12345678 00000300 0c 00000304 00000000 0
4 00000003 00000005 00000304 0d 00000308 0000000f 0
4 00000100 00000100 00000308 0e 0000030c 00010000 0
4 80000000 00000002 0000030c 0f 00000310 00000000 0
4 0000ffff 0000ffff 00000310 10 00000314 fffe0001 0
4 fffffffd 00000004 00000314 11 00000318 fffffff4 0
4 01010101 00000011 00000318 12 0000031c 11111111 0
0 7fffffff 00000001 0000031c 13 00000320 80000000 0
1 00000000 00000001 00000320 14 00000324 ffffffff 0
4 00000009 00000009 00000324 00 00000328 00000000 0
3 80000000 7fffffff 00000328 15 0000032c 00000001 0
2 aaaaaaaa 55555555 0000032c 16 00000330 ffffffff 0
4 deadbeef 00000001 00000330 17 00000334 deadbeef 0
0 fffffff0 00000010 00000334 18 00000338 00000000 0
1 00000064 00000032 00000338 19 0000033c 00000032 0
6 00000000 00000000 0000033c 00 00000340 00000000 1
